// File: hw/sdram_params.svh
// SDRAM clock, power-up and command timing macros
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

// system clock, also forwarded to the SDRAM pin
`define SDRAM_FREQ 27_000_000

// 100 us power-up wait in clocks
`define SDRAM_INIT_CYCLES (`SDRAM_FREQ / 10_000)

`define SDRAM_CAS_LATENCY 2

// busy window of one read or write, counted from acceptance
`define SDRAM_OP_CYCLES 4

// tRC after an auto-refresh, rounded up with margin
`define SDRAM_REFRESH_CYCLES 6

`endif

// File: hw/mem_req_pkg.sv
// client-side request types: address, data word, byte mask and operation

package mem_req_pkg;

    // bank 22:21, row 20:10, column 9:0
    typedef logic [22:0] mem_addr_t;

    typedef logic [31:0] mem_word_t;

    // one bit per byte, set means keep the stored byte
    typedef logic [3:0] mem_mask_t;

    typedef enum logic [1:0] {
        op_read    = 2'd0,
        op_write   = 2'd1,
        op_refresh = 2'd2
    } mem_op_t;

endpackage

// File: hw/sdram_cmd_pkg.sv
// SDRAM command pin encoding and sequencer states

package sdram_cmd_pkg;

    // bit order {ncs, nras, ncas, nwe}
    typedef enum logic [3:0] {
        nop          = 4'b0111,
        activate     = 4'b0011,
        read         = 4'b0101,
        write        = 4'b0100,
        precharge    = 4'b0010,
        auto_refresh = 4'b0001,
        load_mode    = 4'b0000
    } sdram_cmd_t;

    typedef enum logic [2:0] {
        init_wait,  // power-up delay
        init_pre,   // precharge all banks
        init_ref,   // two auto-refreshes
        init_mode,  // mode register load
        idle,
        run         // one request in flight
    } seq_state_t;

endpackage

// File: hw/mem_cmd_if.sv
// request and result signals between the front end and the command sequencer
`timescale 1ns/1ps

interface mem_cmd_if;
    import mem_req_pkg::*;

    logic      start;       // single-cycle request strobe
    mem_op_t   op;
    mem_addr_t addr;
    mem_word_t wdata;
    mem_mask_t mask;

    logic      ready;       // sequencer idle and initialized
    mem_word_t rdata;
    logic      data_ready;  // rdata valid this cycle

    modport ctrl (
        output start, op, addr, wdata, mask,
        input  ready, rdata, data_ready
    );

    modport seq (
        input  start, op, addr, wdata, mask,
        output ready, rdata, data_ready
    );

endinterface

// File: hw/mem_controller.sv
// request front end: capture, busy window, per-client read latches, write count, fail flag
`timescale 1ns/1ps
`include "sdram_params.svh"

module mem_controller (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   read_a,
    input  logic                   read_b,
    input  logic                   write,
    input  logic                   refresh,
    input  mem_req_pkg::mem_addr_t addr,
    input  mem_req_pkg::mem_word_t din,
    input  mem_req_pkg::mem_mask_t mask,
    output mem_req_pkg::mem_word_t dout_a,
    output mem_req_pkg::mem_word_t dout_b,
    output logic                   busy,
    output logic                   mem_initialized,
    output logic                   fail,
    output logic [19:0]            total_written,
    mem_cmd_if.ctrl                cmd
);
    import mem_req_pkg::*;

    logic [3:0] cycles;        // cycles since acceptance, saturating
    logic       r_read_a;
    logic       r_read_b;
    logic       r_refresh;
    logic       any_req;
    logic       any_read;
    logic       last_cycle;
    mem_word_t  da;
    mem_word_t  db;

    assign any_read = read_a | read_b;
    assign any_req  = any_read | write | refresh;

    // request goes straight through in the accepting cycle
    assign cmd.start = ~busy & any_req;
    assign cmd.addr  = addr;
    assign cmd.wdata = din;
    assign cmd.mask  = mask;

    always_comb begin
        if (any_read)
            cmd.op = op_read;    // reads win
        else if (write)
            cmd.op = op_write;
        else
            cmd.op = op_refresh;
    end

    assign last_cycle = r_refresh ? (cycles == 4'(`SDRAM_REFRESH_CYCLES))
                                  : (cycles == 4'(`SDRAM_OP_CYCLES));

    // word shows up in the last busy cycle, held afterwards
    assign dout_a = (r_read_a && last_cycle) ? cmd.rdata : da;
    assign dout_b = (r_read_b && last_cycle) ? cmd.rdata : db;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy            <= 1'b1;
            mem_initialized <= 1'b0;
            fail            <= 1'b0;
            total_written   <= '0;
            cycles          <= '0;
            r_read_a        <= 1'b0;
            r_read_b        <= 1'b0;
            r_refresh       <= 1'b0;
        end else begin
            if (cycles != 4'hf)
                cycles <= cycles + 4'd1;

            if (!busy) begin
                if (any_req) begin
                    busy      <= 1'b1;
                    cycles    <= 4'd1;
                    r_read_a  <= read_a;
                    r_read_b  <= read_b;
                    r_refresh <= refresh & ~any_read & ~write;
                    if (write && !any_read)
                        total_written <= total_written + 20'd1;
                end
            end else if (!mem_initialized) begin
                if (cmd.ready) begin    // init sequence finished
                    mem_initialized <= 1'b1;
                    busy            <= 1'b0;
                end
            end else if (last_cycle) begin
                busy <= 1'b0;
                if (r_read_a || r_read_b) begin
                    if (!cmd.data_ready)
                        fail <= 1'b1;   // read deadline missed
                    r_read_a <= 1'b0;
                    r_read_b <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy && mem_initialized && last_cycle) begin
            if (r_read_a)
                da <= cmd.rdata;
            if (r_read_b)
                db <= cmd.rdata;
        end
    end

    // the sequencer must be idle whenever a request is handed over
    start_needs_ready: assert property (
        @(posedge clk) disable iff (!resetn)
        cmd.start |-> cmd.ready
    );

endmodule

// File: hw/sdram_sequencer.sv
// SDRAM power-up initialization and per-request activate / read / write / refresh commands
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_sequencer (
    input  logic                     clk,
    input  logic                     resetn,
    mem_cmd_if.seq                   cmd,
    output sdram_cmd_pkg::sdram_cmd_t sdram_cmd,
    output logic [10:0]              sdram_a,
    output logic [1:0]               sdram_ba,
    output logic [3:0]               sdram_dqm,
    output logic [31:0]              dq_out,
    output logic                     dq_oe,
    input  logic [31:0]              dq_in,
    output logic                     sdram_cke
);
    import mem_req_pkg::*;
    import sdram_cmd_pkg::*;

    localparam logic [15:0] init_last   = 16'(`SDRAM_INIT_CYCLES - 1);
    localparam logic [15:0] trp_last    = 16'd2;
    localparam logic [15:0] tmrd_last   = 16'd2;
    localparam logic [15:0] ref_last    = 16'(`SDRAM_REFRESH_CYCLES);
    localparam logic [15:0] op_last     = 16'(`SDRAM_OP_CYCLES);
    localparam logic [15:0] rd_data_cnt = 16'(2 + `SDRAM_CAS_LATENCY);

    // burst length 1, sequential, CAS latency from params
    localparam logic [10:0] mode_word = {4'b0000, 3'(`SDRAM_CAS_LATENCY), 1'b0, 3'b000};

    seq_state_t  state;
    logic [15:0] cnt;
    logic        second_ref;
    logic [15:0] run_last;
    mem_op_t     op_q;
    mem_addr_t   addr_q;
    mem_word_t   wdata_q;
    mem_mask_t   mask_q;

    assign sdram_cke = 1'b1;
    assign run_last  = (op_q == op_refresh) ? ref_last : op_last;

    assign cmd.ready      = (state == idle);
    assign cmd.rdata      = dq_in;   // valid in the data_ready cycle
    assign cmd.data_ready = (state == run) && (op_q == op_read) && (cnt == rd_data_cnt);

    always_ff @(posedge clk) begin
        sdram_cmd <= nop;
        sdram_dqm <= 4'h0;
        dq_oe     <= 1'b0;
        cnt       <= cnt + 16'd1;

        case (state)
            init_wait: begin
                if (cnt == init_last) begin
                    sdram_cmd <= precharge;
                    sdram_a   <= 11'h400;   // A10 selects all banks
                    state     <= init_pre;
                    cnt       <= 16'd1;
                end
            end
            init_pre: begin
                if (cnt == trp_last) begin
                    sdram_cmd <= auto_refresh;
                    state     <= init_ref;
                    cnt       <= 16'd1;
                end
            end
            init_ref: begin
                if (cnt == ref_last) begin
                    cnt <= 16'd1;
                    if (!second_ref) begin
                        sdram_cmd  <= auto_refresh;
                        second_ref <= 1'b1;
                    end else begin
                        sdram_cmd <= load_mode;
                        sdram_a   <= mode_word;
                        sdram_ba  <= 2'b00;
                        state     <= init_mode;
                    end
                end
            end
            init_mode: begin
                if (cnt == tmrd_last)
                    state <= idle;
            end
            idle: begin
                if (cmd.start) begin
                    op_q    <= cmd.op;
                    addr_q  <= cmd.addr;
                    wdata_q <= cmd.wdata;
                    mask_q  <= cmd.mask;
                    state   <= run;
                    cnt     <= 16'd1;
                    if (cmd.op == op_refresh) begin
                        sdram_cmd <= auto_refresh;
                    end else begin
                        sdram_cmd <= activate;
                        sdram_a   <= cmd.addr[20:10];   // row
                        sdram_ba  <= cmd.addr[22:21];
                    end
                end
            end
            run: begin
                if (cnt == 16'd1 && op_q != op_refresh) begin
                    sdram_a <= {1'b1, addr_q[9:0]};   // column, auto-precharge
                    if (op_q == op_read) begin
                        sdram_cmd <= read;
                    end else begin
                        sdram_cmd <= write;
                        dq_out    <= wdata_q;
                        sdram_dqm <= mask_q;
                        dq_oe     <= 1'b1;
                    end
                end
                if (cnt == run_last)
                    state <= idle;
            end
            default: state <= init_wait;
        endcase

        if (!resetn) begin
            state      <= init_wait;
            cnt        <= '0;
            second_ref <= 1'b0;
            sdram_cmd  <= nop;
            dq_oe      <= 1'b0;
        end
    end

    // column commands only ever follow their row activate
    rw_after_activate: assert property (
        @(posedge clk) disable iff (!resetn)
        (sdram_cmd inside {read, write}) |-> ($past(sdram_cmd) == activate)
    );

    oe_on_write_only: assert property (
        @(posedge clk) disable iff (!resetn)
        dq_oe |-> (sdram_cmd == write)
    );

endmodule

// File: hw/sdram_top.sv
// memory subsystem top: request front end plus SDRAM sequencer on plain pins
`timescale 1ns/1ps

module sdram_top (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   read_a,
    input  logic                   read_b,
    input  logic                   write,
    input  logic                   refresh,
    input  mem_req_pkg::mem_addr_t addr,
    input  mem_req_pkg::mem_word_t din,
    input  mem_req_pkg::mem_mask_t mask,
    output mem_req_pkg::mem_word_t dout_a,
    output mem_req_pkg::mem_word_t dout_b,
    output logic                   busy,
    output logic                   mem_initialized,
    output logic                   fail,
    output logic [19:0]            total_written,
    output logic                   sdram_ncs,
    output logic                   sdram_nras,
    output logic                   sdram_ncas,
    output logic                   sdram_nwe,
    output logic [10:0]            sdram_a,
    output logic [1:0]             sdram_ba,
    output logic [3:0]             sdram_dqm,
    output logic [31:0]            dq_out,
    output logic                   dq_oe,
    input  logic [31:0]            dq_in,
    output logic                   sdram_cke,
    output logic                   sdram_clk
);
    import sdram_cmd_pkg::*;

    sdram_cmd_t seq_cmd;

    mem_cmd_if cmd_if ();

    mem_controller ctrl_inst (
        .clk             (clk),
        .resetn          (resetn),
        .read_a          (read_a),
        .read_b          (read_b),
        .write           (write),
        .refresh         (refresh),
        .addr            (addr),
        .din             (din),
        .mask            (mask),
        .dout_a          (dout_a),
        .dout_b          (dout_b),
        .busy            (busy),
        .mem_initialized (mem_initialized),
        .fail            (fail),
        .total_written   (total_written),
        .cmd             (cmd_if.ctrl)
    );

    sdram_sequencer seq_inst (
        .clk       (clk),
        .resetn    (resetn),
        .cmd       (cmd_if.seq),
        .sdram_cmd (seq_cmd),
        .sdram_a   (sdram_a),
        .sdram_ba  (sdram_ba),
        .sdram_dqm (sdram_dqm),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe),
        .dq_in     (dq_in),
        .sdram_cke (sdram_cke)
    );

    assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = seq_cmd;
    assign sdram_clk = clk;   // same phase as the logic clock

endmodule

// File: testbench/sdram_model.sv
// behavioral SDRAM: command decode, row tracking per bank, masked writes,
// read data returned after CAS latency
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_model (
    input  logic        clk,
    input  logic        resetn,
    input  logic        ncs,
    input  logic        nras,
    input  logic        ncas,
    input  logic        nwe,
    input  logic [10:0] a,
    input  logic [1:0]  ba,
    input  logic [3:0]  dqm,
    input  logic [31:0] dq_out,
    input  logic        dq_oe,
    output logic [31:0] dq_in,
    output logic        order_error
);
    import sdram_cmd_pkg::*;

    localparam int cl = `SDRAM_CAS_LATENCY;

    sdram_cmd_t  cmd;
    logic [31:0] store [logic [22:0]];   // keyed by {bank, row, column}
    logic [10:0] open_row [4];
    logic [3:0]  row_open;
    logic [31:0] rd_pipe [cl];           // read data on its way to the pins
    logic [22:0] key;
    logic [31:0] word;
    int          wait_cnt;

    assign cmd   = sdram_cmd_t'({ncs, nras, ncas, nwe});
    assign key   = {ba, open_row[ba], a[9:0]};
    assign dq_in = rd_pipe[cl - 1];

    initial begin
        for (int i = 0; i < cl; i++)
            rd_pipe[i] = 32'h0;
        order_error = 1'b0;
    end

    always @(posedge clk) begin
        order_error <= 1'b0;
        for (int i = cl - 1; i > 0; i--)
            rd_pipe[i] <= rd_pipe[i - 1];
        rd_pipe[0] <= 32'h0;

        if (!resetn) begin
            wait_cnt <= 0;
            row_open <= 4'h0;
        end else begin
            if (wait_cnt < `SDRAM_INIT_CYCLES) begin
                wait_cnt <= wait_cnt + 1;
                if (cmd != nop)
                    order_error <= 1'b1;   // device still powering up
            end
            case (cmd)
                activate: begin
                    if (row_open[ba])
                        order_error <= 1'b1;
                    row_open[ba] <= 1'b1;
                    open_row[ba] <= a;
                end
                read, write: begin
                    if (!row_open[ba])
                        order_error <= 1'b1;   // no row to address
                    if (a[10])
                        row_open[ba] <= 1'b0;   // auto-precharge
                    word = store.exists(key) ? store[key] : 32'h0;
                    if (cmd == read) begin
                        rd_pipe[0] <= word;
                    end else begin
                        if (!dq_oe)
                            order_error <= 1'b1;
                        for (int b = 0; b < 4; b++)
                            if (!dqm[b])
                                word[8*b +: 8] = dq_out[8*b +: 8];
                        store[key] = word;
                    end
                end
                precharge: begin
                    if (a[10])
                        row_open <= 4'h0;
                    else
                        row_open[ba] <= 1'b0;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: testbench/tb_sdram_top.sv
// testbench for the SDRAM subsystem: clock, reset, client stimulus,
// reference memory, concurrent checks, watchdog and summary
`timescale 1ns/1ps
`include "sdram_params.svh"

module tb_sdram_top;
    import mem_req_pkg::*;

    localparam int kind_read_a  = 0;
    localparam int kind_read_b  = 1;
    localparam int kind_write   = 2;
    localparam int kind_refresh = 3;
    // init wait plus 200 refresh-length operations, doubled
    localparam int watchdog_cycles = (`SDRAM_INIT_CYCLES + 200 * `SDRAM_REFRESH_CYCLES) * 2;

    logic        clk = 1'b0;
    logic        resetn;
    logic        read_a;
    logic        read_b;
    logic        write;
    logic        refresh;
    mem_addr_t   addr;
    mem_word_t   din;
    mem_mask_t   mask;
    mem_word_t   dout_a;
    mem_word_t   dout_b;
    logic        busy;
    logic        mem_initialized;
    logic        fail;
    logic [19:0] total_written;
    logic        sdram_ncs;
    logic        sdram_nras;
    logic        sdram_ncas;
    logic        sdram_nwe;
    logic [10:0] sdram_a;
    logic [1:0]  sdram_ba;
    logic [3:0]  sdram_dqm;
    logic [31:0] dq_out;
    logic        dq_oe;
    logic [31:0] dq_in;
    logic        sdram_cke;
    logic        sdram_clk;
    logic        order_error;

    mem_word_t   ref_mem [mem_addr_t];   // expected memory contents
    mem_addr_t   addr_pool [8];
    logic        accept;
    int          run_len;    // busy cycles seen since acceptance
    int          exp_len;
    logic        acc_a;
    logic        acc_b;
    mem_word_t   exp_word;
    mem_word_t   held_a;
    mem_word_t   held_b;
    logic        a_seen;
    logic        b_seen;
    mem_word_t   want_a;
    mem_word_t   want_b;
    logic        check_a;
    logic        check_b;
    logic [19:0] wr_count;
    int          errors = 0;
    int          op_count = 0;

    always #2 clk = ~clk;

    sdram_top sdram_top_inst (
        .clk (clk), .resetn (resetn),
        .read_a (read_a), .read_b (read_b), .write (write), .refresh (refresh),
        .addr (addr), .din (din), .mask (mask),
        .dout_a (dout_a), .dout_b (dout_b),
        .busy (busy), .mem_initialized (mem_initialized), .fail (fail),
        .total_written (total_written),
        .sdram_ncs (sdram_ncs), .sdram_nras (sdram_nras),
        .sdram_ncas (sdram_ncas), .sdram_nwe (sdram_nwe),
        .sdram_a (sdram_a), .sdram_ba (sdram_ba), .sdram_dqm (sdram_dqm),
        .dq_out (dq_out), .dq_oe (dq_oe), .dq_in (dq_in),
        .sdram_cke (sdram_cke), .sdram_clk (sdram_clk)
    );

    sdram_model model_inst (
        .clk (sdram_clk), .resetn (resetn),
        .ncs (sdram_ncs), .nras (sdram_nras), .ncas (sdram_ncas), .nwe (sdram_nwe),
        .a (sdram_a), .ba (sdram_ba), .dqm (sdram_dqm),
        .dq_out (dq_out), .dq_oe (dq_oe), .dq_in (dq_in),
        .order_error (order_error)
    );

    function automatic mem_word_t ref_word(input mem_addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : 32'h0;
    endfunction

    // a set mask bit keeps the stored byte
    function automatic mem_word_t apply_mask(input mem_word_t old, input mem_word_t d,
                                             input mem_mask_t m);
        mem_word_t w;
        w = old;
        for (int i = 0; i < 4; i++)
            if (!m[i])
                w[8*i +: 8] = d[8*i +: 8];
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        errors = errors + 1;
        $display("CHECK FAILED %s: got %h, expected %h", name, got, want);
    endtask

    task automatic record_failure(input string msg);
        errors = errors + 1;
        $display("%s", msg);
    endtask

    task automatic print_summary();
        $display("summary: %0d errors, %0d requests, %0d writes accepted",
                 errors, op_count, wr_count);
    endtask

    // one strobe for one cycle, once busy is low
    task automatic send_request(input int kind, input mem_addr_t a, input mem_word_t d,
                                input mem_mask_t m);
        while (busy) begin
            @(posedge clk);
            #1;
        end
        addr    = a;
        din     = d;
        mask    = m;
        read_a  = (kind == kind_read_a);
        read_b  = (kind == kind_read_b);
        write   = (kind == kind_write);
        refresh = (kind == kind_refresh);
        op_count++;
        @(posedge clk);
        #1;
        read_a  = 1'b0;
        read_b  = 1'b0;
        write   = 1'b0;
        refresh = 1'b0;
    endtask

    // write strobe that lands while a request is still running
    task automatic write_while_busy(input mem_addr_t a, input mem_word_t d);
        addr  = a;
        din   = d;
        mask  = 4'h0;
        write = 1'b1;
        @(posedge clk);
        #1;
        write = 1'b0;
    endtask

    assign accept  = resetn && !busy && (read_a || read_b || write || refresh);
    assign want_a  = (acc_a && run_len == exp_len) ? exp_word : held_a;
    assign want_b  = (acc_b && run_len == exp_len) ? exp_word : held_b;
    assign check_a = a_seen || (acc_a && run_len == exp_len);
    assign check_b = b_seen || (acc_b && run_len == exp_len);

    // reference side: follows every accepted strobe
    always @(posedge clk) begin
        if (!resetn) begin
            run_len  <= 0;
            exp_len  <= 0;
            acc_a    <= 1'b0;
            acc_b    <= 1'b0;
            a_seen   <= 1'b0;
            b_seen   <= 1'b0;
            wr_count <= 20'h0;
        end else begin
            if (accept) begin
                run_len  <= 1;
                exp_len  <= (refresh && !read_a && !read_b && !write) ?
                            `SDRAM_REFRESH_CYCLES : `SDRAM_OP_CYCLES;
                acc_a    <= read_a;
                acc_b    <= read_b;
                exp_word <= ref_word(addr);
                if (write && !read_a && !read_b) begin
                    ref_mem[addr] = apply_mask(ref_word(addr), din, mask);
                    wr_count <= wr_count + 20'd1;
                end
            end else if (run_len != 0 && run_len <= exp_len) begin
                run_len <= run_len + 1;
            end else begin
                run_len <= 0;
            end
            if (acc_a && run_len == exp_len) begin
                held_a <= exp_word;
                a_seen <= 1'b1;
            end
            if (acc_b && run_len == exp_len) begin
                held_b <= exp_word;
                b_seen <= 1'b1;
            end
        end
    end

    busy_until_init: assert property (@(posedge clk) disable iff (!resetn)
        !mem_initialized |-> busy)
        else report_mismatch("busy", 32'($sampled(busy)), 32'h1);
    init_stays_set: assert property (@(posedge clk) disable iff (!resetn)
        $past(mem_initialized) |-> mem_initialized)
        else report_mismatch("mem_initialized", 32'($sampled(mem_initialized)), 32'h1);
    fail_stays_low: assert property (@(posedge clk) disable iff (!resetn) !fail)
        else report_mismatch("fail", 32'($sampled(fail)), 32'h0);
    cke_high: assert property (@(posedge clk) disable iff (!resetn) sdram_cke)
        else report_mismatch("sdram_cke", 32'($sampled(sdram_cke)), 32'h1);
    busy_in_window: assert property (@(posedge clk) disable iff (!resetn)
        (run_len != 0 && run_len <= exp_len) |-> busy)
        else report_mismatch("busy", 32'($sampled(busy)), 32'h1);
    busy_after_window: assert property (@(posedge clk) disable iff (!resetn)
        (run_len == exp_len + 1) |-> !busy)
        else report_mismatch("busy", 32'($sampled(busy)), 32'h0);
    dout_a_value: assert property (@(posedge clk) disable iff (!resetn)
        check_a |-> dout_a == want_a)
        else report_mismatch("dout_a", $sampled(dout_a), $sampled(want_a));
    dout_b_value: assert property (@(posedge clk) disable iff (!resetn)
        check_b |-> dout_b == want_b)
        else report_mismatch("dout_b", $sampled(dout_b), $sampled(want_b));
    write_count: assert property (@(posedge clk) disable iff (!resetn)
        total_written == wr_count)
        else report_mismatch("total_written", 32'($sampled(total_written)),
                             32'($sampled(wr_count)));
    command_order: assert property (@(posedge clk) disable iff (!resetn) !order_error)
        else record_failure("SDRAM model saw a command out of order or during power-up");

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        print_summary();
        $display("tests failed");
        $finish;
    end

    initial begin
        mem_addr_t a;
        void'($urandom(32'hdc4d_e670));
        resetn  = 1'b0;
        read_a  = 1'b0;
        read_b  = 1'b0;
        write   = 1'b0;
        refresh = 1'b0;
        addr    = '0;
        din     = '0;
        mask    = '0;
        for (int i = 0; i < 8; i++)
            addr_pool[i] = mem_addr_t'($urandom);
        repeat (8) @(posedge clk);
        #1;
        resetn = 1'b1;
        while (!mem_initialized) begin
            @(posedge clk);
            #1;
        end

        // write, then read back on client a while client b holds its word
        send_request(kind_read_b, addr_pool[7], '0, '0);
        for (int i = 0; i < 8; i++) begin
            send_request(kind_write, addr_pool[i], $urandom, 4'h0);
            send_request(kind_read_a, addr_pool[i], '0, '0);
        end

        // partial writes under random byte masks
        for (int i = 0; i < 8; i++) begin
            a = addr_pool[$urandom % 8];
            send_request(kind_write, a, $urandom, mem_mask_t'($urandom));
            send_request(kind_read_b, a, '0, '0);
        end

        // strobes while busy are dropped
        send_request(kind_write, addr_pool[0], $urandom, 4'h0);
        write_while_busy(addr_pool[0], $urandom);
        send_request(kind_refresh, '0, '0, '0);
        write_while_busy(addr_pool[0], $urandom);
        send_request(kind_read_a, addr_pool[0], '0, '0);

        for (int i = 0; i < 100; i++)
            send_request(int'($urandom % 4), addr_pool[$urandom % 8], $urandom,
                         mem_mask_t'($urandom));

        while (busy) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        print_summary();
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: sim.f
+incdir+hw
hw/mem_req_pkg.sv
hw/sdram_cmd_pkg.sv
hw/mem_cmd_if.sv
hw/mem_controller.sv
hw/sdram_sequencer.sv
hw/sdram_top.sv
testbench/sdram_model.sv
testbench/tb_sdram_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the SDRAM subsystem testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_sdram_top -f sim.f -o tb_sdram_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_sdram_top 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
